//--- src.f
flash_pkg.sv
spi_flash_reader.sv
fetch_arbiter.sv
dbus_flash_bridge.sv
flash_xip_top.sv
tb_flash_model.sv
tb_checker.sv
tb_top.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f src.f --top-module tb_top -o sim_tb || exit 1
out=$(./obj_dir/sim_tb)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TEST OK" && echo "simulation passed" && exit 0 || {
    echo "simulation failed"
    exit 1
}

//--- tb_top.sv
/*
 * Testbench top for the flash XIP fetch path, plays both bus masters.
 * Rows of the stimulus table run one after another, with idle gaps between.
 */
`timescale 1ns/10ps

module tb_top;

    typedef enum logic [1:0] {m_ibus, m_dbus, m_both, m_reset} mode_e;

    typedef struct packed {
        mode_e       mode;
        logic        we;
        logic        rnd;
        logic [31:0] iadr;
        logic [31:0] dadr;
    } row_t;

    localparam int NUM_ROWS = 13;
    localparam int ACK_TIMEOUT = 400;

    logic        ck;
    logic        reset_loop;
    logic [31:0] ibus_adr;
    logic        ibus_cyc;
    logic        ibus_ack;
    logic [31:0] ibus_rdt;
    logic [31:0] dbus_adr;
    logic        dbus_we;
    logic        dbus_cyc;
    logic        dbus_ack;
    logic [31:0] dbus_rdt;
    logic        spi_cs;
    logic        spi_sck;
    logic        spi_mosi;
    logic        spi_miso;

    row_t rows [NUM_ROWS];

    always #20 ck = ~ck;

    flash_xip_top uut (.*);

    tb_flash_model flash (
        .spi_cs   (spi_cs),
        .spi_sck  (spi_sck),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

    tb_checker chk (
        .ck         (ck),
        .reset_loop (reset_loop),
        .ibus_adr   (ibus_adr),
        .ibus_ack   (ibus_ack),
        .ibus_rdt   (ibus_rdt),
        .dbus_adr   (dbus_adr),
        .dbus_we    (dbus_we),
        .dbus_ack   (dbus_ack),
        .dbus_rdt   (dbus_rdt),
        .spi_cs     (spi_cs),
        .spi_sck    (spi_sck)
    );

    task automatic apply_row(input int idx, input row_t r);
        mode_e mode;
        logic  use_d;
        logic  quiet;
        logic  i_seen;
        logic  d_seen;
        logic  done;
        int    exp_i;
        int    exp_d;
        int    exp_x;
        int    waited;
        mode   = r.mode;
        use_d  = (mode == m_dbus) || (mode == m_both);
        exp_i  = (mode == m_ibus || mode == m_both) ? 1 : 0;
        exp_d  = (use_d && r.dadr[31:24] == flash_pkg::DBUS_WIN_TAG) ? 1 : 0;
        // Outside the window nobody answers, the whole timeout is waited out
        quiet  = use_d && (exp_d == 0);
        exp_x  = (mode == m_reset) ? 1 : exp_i + ((exp_d == 1 && !r.we) ? 1 : 0);
        i_seen = 1'b0;
        d_seen = 1'b0;
        done   = 1'b0;
        waited = 0;
        chk.open_test(exp_i, exp_d, exp_x, mode == m_both);
        @(negedge ck);
        ibus_adr = r.iadr;
        ibus_cyc = (mode != m_dbus);
        dbus_adr = r.dadr;
        dbus_we  = r.we;
        dbus_cyc = use_d;
        if (mode == m_reset) begin
            while (spi_cs && waited < ACK_TIMEOUT) begin
                @(negedge ck);
                waited++;
            end
            if (spi_cs)
                chk.report_timeout($sformatf("test %0d flash transaction never started", idx));
            // Reset lands well inside the address phase
            repeat (40) @(negedge ck);
            reset_loop = 1'b1;
            ibus_cyc = 1'b0;
            repeat (4) @(negedge ck);
            reset_loop = 1'b0;
        end else begin
            while (!done && waited < ACK_TIMEOUT) begin
                @(negedge ck);
                waited++;
                // Each master drops cyc in the cycle after its ack
                if (i_seen)
                    ibus_cyc = 1'b0;
                if (d_seen)
                    dbus_cyc = 1'b0;
                if (ibus_ack)
                    i_seen = 1'b1;
                if (dbus_ack)
                    d_seen = 1'b1;
                done = !quiet && (exp_i == 0 || (i_seen && !ibus_cyc)) &&
                       (exp_d == 0 || (d_seen && !dbus_cyc));
            end
            if (!done && !quiet)
                chk.report_timeout($sformatf("test %0d got no ack within %0d cycles",
                                             idx, ACK_TIMEOUT));
        end
        @(negedge ck);
        ibus_cyc = 1'b0;
        dbus_cyc = 1'b0;
        dbus_we  = 1'b0;
        repeat (4) @(negedge ck);
        chk.close_test(idx, $sformatf("%s we=%0b ibus %h dbus %h",
                                      mode.name(), r.we, r.iadr, r.dadr));
    endtask

    initial begin
        void'($urandom(73025));
        ck         = 1'b0;
        reset_loop = 1'b1;
        ibus_adr   = '0;
        ibus_cyc   = 1'b0;
        dbus_adr   = '0;
        dbus_we    = 1'b0;
        dbus_cyc   = 1'b0;

        rows[0]  = '{m_ibus,  1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000};
        rows[1]  = '{m_ibus,  1'b0, 1'b0, 32'h0000_1234, 32'h0000_0000};
        rows[2]  = '{m_ibus,  1'b0, 1'b1, 32'h0000_0000, 32'h0000_0000};
        rows[3]  = '{m_ibus,  1'b0, 1'b1, 32'h0000_0000, 32'h0000_0000};
        rows[4]  = '{m_dbus,  1'b0, 1'b0, 32'h0000_0000, 32'h40AB_CDEC};
        rows[5]  = '{m_dbus,  1'b0, 1'b1, 32'h0000_0000, 32'h0000_0000};
        rows[6]  = '{m_dbus,  1'b0, 1'b0, 32'h0000_0000, 32'h2000_0010};
        rows[7]  = '{m_dbus,  1'b1, 1'b0, 32'h0000_0000, 32'h4000_0100};
        rows[8]  = '{m_both,  1'b0, 1'b0, 32'h0000_0400, 32'h40FF_FFFC};
        rows[9]  = '{m_both,  1'b0, 1'b1, 32'h0000_0000, 32'h0000_0000};
        rows[10] = '{m_reset, 1'b0, 1'b0, 32'h0000_2000, 32'h0000_0000};
        rows[11] = '{m_ibus,  1'b0, 1'b0, 32'h0000_2000, 32'h0000_0000};
        rows[12] = '{m_dbus,  1'b0, 1'b0, 32'h0000_0000, 32'h4000_0103};

        // Random rows keep dbus inside the flash window
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (rows[i].rnd) begin
                rows[i].iadr = $urandom();
                rows[i].dadr = {flash_pkg::DBUS_WIN_TAG, 24'($urandom())};
            end
        end

        repeat (4) @(negedge ck);
        reset_loop = 1'b0;

        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(i, rows[i]);
        end

        chk.print_totals();
        if (chk.error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- tb_checker.sv
/*
 * Watches the DUT ports and compares every ack with the flash content rule.
 * Tests are framed by open_test and close_test calls from the testbench top.
 */
`timescale 1ns/10ps

module tb_checker (
    input logic        ck,
    input logic        reset_loop,
    input logic [31:0] ibus_adr,
    input logic        ibus_ack,
    input logic [31:0] ibus_rdt,
    input logic [31:0] dbus_adr,
    input logic        dbus_we,
    input logic        dbus_ack,
    input logic [31:0] dbus_rdt,
    input logic        spi_cs,
    input logic        spi_sck
);

    int cycle = 0;
    int i_acks = 0;
    int d_acks = 0;
    int xfers = 0;
    int first_i = -1;
    int first_d = -1;
    int exp_i = 0;
    int exp_d = 0;
    int exp_x = 0;
    int test_errors = 0;
    int error_count = 0;
    int tests_run = 0;
    int tests_failed = 0;
    logic want_order = 1'b0;
    logic cs_q = 1'b1;
    logic rst_q = 1'b0;
    logic [31:0] d_exp;

    function automatic logic [7:0] flash_byte(input logic [23:0] a);
        return a[7:0] + a[15:8] + a[15:8] + a[15:8] + 8'h5a;
    endfunction

    // Little-endian word at the aligned flash address
    function automatic logic [31:0] flash_word(input logic [31:0] adr);
        logic [23:0] base;
        base = {adr[23:2], 2'b00};
        return {flash_byte(base + 24'd3), flash_byte(base + 24'd2),
                flash_byte(base + 24'd1), flash_byte(base)};
    endfunction

    task automatic flag_error(input string msg);
        $display("ERROR at %0d ns: %s", $time, msg);
        test_errors++;
        error_count++;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s", what);
        test_errors++;
        error_count++;
    endtask

    task automatic open_test(input int n_i, input int n_d, input int n_x, input logic order);
        exp_i = n_i;
        exp_d = n_d;
        exp_x = n_x;
        want_order = order;
        i_acks = 0;
        d_acks = 0;
        xfers = 0;
        first_i = -1;
        first_d = -1;
        test_errors = 0;
    endtask

    task automatic close_test(input int idx, input string label);
        if (i_acks != exp_i)
            flag_error($sformatf("%0d ibus acks, expected %0d", i_acks, exp_i));
        if (d_acks != exp_d)
            flag_error($sformatf("%0d dbus acks, expected %0d", d_acks, exp_d));
        if (xfers != exp_x)
            flag_error($sformatf("%0d flash transactions, expected %0d", xfers, exp_x));
        if (want_order && first_i >= 0 && first_d >= 0 && first_d <= first_i)
            flag_error("dbus ack came before ibus ack");
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d %s: pass", idx, label);
        end else begin
            tests_failed++;
            $display("test %0d %s: fail, %0d errors", idx, label, test_errors);
        end
    endtask

    task automatic print_totals();
        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, error_count);
    endtask

    always @(posedge ck) begin
        cycle++;
        if (cs_q && !spi_cs)
            xfers++;
        cs_q = spi_cs;
        if (rst_q && (!spi_cs || spi_sck || ibus_ack || dbus_ack))
            flag_error("flash pins or acks not idle after reset");
        rst_q = reset_loop;
        if (ibus_ack) begin
            i_acks++;
            if (first_i < 0)
                first_i = cycle;
            if (ibus_rdt !== flash_word(ibus_adr))
                flag_error($sformatf("ibus rdt %h at %h, expected %h",
                                     ibus_rdt, ibus_adr, flash_word(ibus_adr)));
        end else if (ibus_rdt !== 32'h0) begin
            flag_error($sformatf("ibus rdt %h without ack", ibus_rdt));
        end
        if (dbus_ack) begin
            d_acks++;
            if (first_d < 0)
                first_d = cycle;
            // Writes are acked with zero data
            d_exp = dbus_we ? 32'h0 : flash_word(dbus_adr);
            if (dbus_rdt !== d_exp)
                flag_error($sformatf("dbus rdt %h at %h, expected %h",
                                     dbus_rdt, dbus_adr, d_exp));
        end else if (dbus_rdt !== 32'h0) begin
            flag_error($sformatf("dbus rdt %h without ack", dbus_rdt));
        end
    end

endmodule

//--- tb_flash_model.sv
/*
 * SPI mode-0 flash that only understands the 03h read of one 32-bit word.
 * Content rule: byte(A) = A[7:0] + 3 * A[15:8] + 5Ah, modulo 256.
 */
`timescale 1ns/10ps

module tb_flash_model (
    input  logic spi_cs,
    input  logic spi_sck,
    input  logic spi_mosi,
    output logic spi_miso
);

    logic [6:0]  bit_cnt;
    logic [31:0] cmd_adr;
    logic [31:0] out_sr;

    function automatic logic [7:0] byte_at(input logic [23:0] a);
        return a[7:0] + a[15:8] + a[15:8] + a[15:8] + 8'h5a;
    endfunction

    initial begin
        bit_cnt = '0;
        cmd_adr = '0;
        out_sr  = '0;
    end

    assign spi_miso = out_sr[31];

    always @(posedge spi_sck or negedge spi_sck or posedge spi_cs) begin
        if (spi_cs) begin
            bit_cnt = '0;
            out_sr  = '0;
        end else if (spi_sck) begin
            // Command and address bits arrive on the rising edge
            if (bit_cnt < 7'd32) begin
                cmd_adr = {cmd_adr[30:0], spi_mosi};
            end
            bit_cnt = bit_cnt + 7'd1;
        end else if (bit_cnt == 7'd32) begin
            // Lowest address byte goes out first, MSB first
            if (cmd_adr[31:24] == 8'h03) begin
                out_sr = {byte_at(cmd_adr[23:0]), byte_at(cmd_adr[23:0] + 24'd1),
                          byte_at(cmd_adr[23:0] + 24'd2), byte_at(cmd_adr[23:0] + 24'd3)};
            end else begin
                out_sr = '0;
            end
        end else if (bit_cnt > 7'd32) begin
            out_sr = {out_sr[30:0], 1'b0};
        end
    end

endmodule

//--- flash_xip_top.sv
/*
 * Flash XIP fetch subsystem: ibus and a dbus window share one SPI reader.
 * Single-lane reads only, IO2/IO3 must be tied high on the board.
 */
`timescale 1ns/10ps

module flash_xip_top (
    input  logic        ck,
    input  logic        reset_loop,
    input  logic [31:0] ibus_adr,
    input  logic        ibus_cyc,
    output logic        ibus_ack,
    output logic [31:0] ibus_rdt,
    input  logic [31:0] dbus_adr,
    input  logic        dbus_we,
    input  logic        dbus_cyc,
    output logic        dbus_ack,
    output logic [31:0] dbus_rdt,
    output logic        spi_cs,
    output logic        spi_sck,
    output logic        spi_mosi,
    input  logic        spi_miso
);

    // Bridge to arbiter side b
    logic        br_cyc;
    logic [31:0] br_adr;
    logic        br_ack;
    logic [31:0] br_rdt;

    // Arbiter to reader
    logic        rd_cyc;
    logic [31:0] rd_adr;
    logic        rd_ack;
    logic [31:0] rd_rdt;

    dbus_flash_bridge u_bridge (
        .ck         (ck),
        .reset_loop (reset_loop),
        .dbus_adr   (dbus_adr),
        .dbus_we    (dbus_we),
        .dbus_cyc   (dbus_cyc),
        .dbus_ack   (dbus_ack),
        .dbus_rdt   (dbus_rdt),
        .br_cyc     (br_cyc),
        .br_adr     (br_adr),
        .br_ack     (br_ack),
        .br_rdt     (br_rdt)
    );

    fetch_arbiter u_arb (
        .ck         (ck),
        .reset_loop (reset_loop),
        .a_cyc      (ibus_cyc),
        .a_adr      (ibus_adr),
        .a_ack      (ibus_ack),
        .a_rdt      (ibus_rdt),
        .b_cyc      (br_cyc),
        .b_adr      (br_adr),
        .b_ack      (br_ack),
        .b_rdt      (br_rdt),
        .x_cyc      (rd_cyc),
        .x_adr      (rd_adr),
        .x_ack      (rd_ack),
        .x_rdt      (rd_rdt)
    );

    spi_flash_reader u_reader (
        .ck         (ck),
        .reset_loop (reset_loop),
        .rd_adr     (rd_adr),
        .rd_cyc     (rd_cyc),
        .rd_ack     (rd_ack),
        .rd_rdt     (rd_rdt),
        .spi_cs     (spi_cs),
        .spi_sck    (spi_sck),
        .spi_mosi   (spi_mosi),
        .spi_miso   (spi_miso)
    );

endmodule

//--- dbus_flash_bridge.sv
/*
 * Maps the data-bus window 40xx_xxxx onto flash byte addresses.
 * Writes into the window are acked and dropped, flash is read only.
 * Addresses outside the window are left for the other slaves.
 */
`timescale 1ns/10ps

module dbus_flash_bridge (
    input  logic        ck,
    input  logic        reset_loop,
    input  logic [31:0] dbus_adr,
    input  logic        dbus_we,
    input  logic        dbus_cyc,
    output logic        dbus_ack,
    output logic [31:0] dbus_rdt,
    output logic        br_cyc,
    output logic [31:0] br_adr,
    input  logic        br_ack,
    input  logic [31:0] br_rdt
);

    logic in_win;
    logic wr_ack;

    assign in_win = (dbus_adr[31:24] == flash_pkg::DBUS_WIN_TAG);

    // Reads go straight through to the arbiter
    assign br_cyc = dbus_cyc && in_win && !dbus_we;

    // Low bits become the flash byte address
    assign br_adr = {{(32 - flash_pkg::FLASH_ADDR_BITS){1'b0}},
                     dbus_adr[flash_pkg::FLASH_ADDR_BITS-1:0]};

    // Write ack, not repeated in the cycle where cyc is still up
    always_ff @(posedge ck) begin
        if (reset_loop) begin
            wr_ack <= 1'b0;
        end else begin
            wr_ack <= dbus_cyc && in_win && dbus_we && !wr_ack;
        end
    end

    assign dbus_ack = br_ack | wr_ack;

    // br_rdt is zero during a write ack
    assign dbus_rdt = br_rdt;

endmodule

//--- fetch_arbiter.sv
/*
 * Two-master arbiter in front of the flash reader.
 * Side a (ibus) wins when both ask in the same cycle.
 * Grant is held until x_ack, masters must keep cyc high until then.
 */
`timescale 1ns/10ps

module fetch_arbiter (
    input  logic        ck,
    input  logic        reset_loop,
    input  logic        a_cyc,
    input  logic [31:0] a_adr,
    output logic        a_ack,
    output logic [31:0] a_rdt,
    input  logic        b_cyc,
    input  logic [31:0] b_adr,
    output logic        b_ack,
    output logic [31:0] b_rdt,
    output logic        x_cyc,
    output logic [31:0] x_adr,
    input  logic        x_ack,
    input  logic [31:0] x_rdt
);

    flash_pkg::arb_owner_e owner;
    flash_pkg::arb_owner_e sel;

    // Pick a new owner combinationally so no cycle is lost
    always_comb begin
        sel = owner;
        if (owner == flash_pkg::own_none) begin
            if (a_cyc) begin
                sel = flash_pkg::own_ibus;
            end else if (b_cyc) begin
                sel = flash_pkg::own_dbus;
            end
        end
    end

    assign x_cyc = (sel == flash_pkg::own_ibus) ? a_cyc :
                   (sel == flash_pkg::own_dbus) ? b_cyc : 1'b0;
    assign x_adr = (sel == flash_pkg::own_dbus) ? b_adr : a_adr;

    // Ack and data only to the owner
    assign a_ack = x_ack && (owner == flash_pkg::own_ibus);
    assign b_ack = x_ack && (owner == flash_pkg::own_dbus);
    assign a_rdt = a_ack ? x_rdt : 32'h0;
    assign b_rdt = b_ack ? x_rdt : 32'h0;

    always_ff @(posedge ck) begin
        if (reset_loop || x_ack) begin
            owner <= flash_pkg::own_none;
        end else if (owner == flash_pkg::own_none) begin
            owner <= sel;
        end
    end

    // Reader never answers a request that has gone away
    a_ack_in_cyc : assert property (@(posedge ck) disable iff (reset_loop)
        x_ack |-> x_cyc);

endmodule

//--- spi_flash_reader.sv
/*
 * SPI mode-0 reader that runs one 03h read per bus request with sck at ck/2.
 * Reads whole words only and ignores bits 1:0 and 31:24 of rd_adr.
 * Latency is 130 cycles from the edge that accepts rd_cyc to rd_ack.
 */
`timescale 1ns/10ps

module spi_flash_reader (
    input  logic        ck,
    input  logic        reset_loop,
    input  logic [31:0] rd_adr,
    input  logic        rd_cyc,
    output logic        rd_ack,
    output logic [31:0] rd_rdt,
    output logic        spi_cs,
    output logic        spi_sck,
    output logic        spi_mosi,
    input  logic        spi_miso
);

    flash_pkg::reader_state_e state;

    // Two ck cycles per sck period over the whole transaction
    logic [$clog2(2 * flash_pkg::XFER_BITS)-1:0] cnt;

    // Command and address going out, then the data word coming in
    logic [31:0] shreg;
    logic [31:0] word_le;

    logic last_out;
    logic last_in;

    // Last ck cycle of the command/address phase and of the data phase
    assign last_out = (cnt == ($bits(cnt))'(2 * (8 + flash_pkg::FLASH_ADDR_BITS) - 1));
    assign last_in  = (cnt == ($bits(cnt))'(2 * flash_pkg::XFER_BITS - 1));

    // First byte received is the lowest address
    assign word_le = {shreg[7:0], shreg[15:8], shreg[23:16], shreg[31:24]};

    // shreg holds its value through the ack cycle
    assign rd_rdt = rd_ack ? word_le : 32'h0;

    // MSB leads and changes together with the falling sck edge
    assign spi_mosi = (state == flash_pkg::st_shift_out) ? shreg[31] : 1'b0;

    always_ff @(posedge ck) begin
        if (reset_loop) begin
            state   <= flash_pkg::st_idle;
            spi_cs  <= 1'b1;
            spi_sck <= 1'b0;
            rd_ack  <= 1'b0;
            cnt     <= '0;
        end else begin
            rd_ack <= 1'b0;
            case (state)
                flash_pkg::st_idle: begin
                    // Master still holds cyc during its ack cycle
                    if (rd_cyc && !rd_ack) begin
                        state  <= flash_pkg::st_shift_out;
                        spi_cs <= 1'b0;
                        cnt    <= '0;
                    end
                end
                flash_pkg::st_shift_out: begin
                    spi_sck <= ~cnt[0];
                    cnt     <= cnt + ($bits(cnt))'(1);
                    if (last_out) begin
                        state <= flash_pkg::st_shift_in;
                    end
                end
                flash_pkg::st_shift_in: begin
                    spi_sck <= ~cnt[0];
                    cnt     <= cnt + ($bits(cnt))'(1);
                    if (last_in) begin
                        state  <= flash_pkg::st_done;
                        spi_cs <= 1'b1;
                    end
                end
                default: begin
                    state  <= flash_pkg::st_idle;
                    rd_ack <= 1'b1;
                end
            endcase
        end
    end

    // Loads command and address, shifts them out and the data word in
    always_ff @(posedge ck) begin
        if (state == flash_pkg::st_idle) begin
            if (rd_cyc && !rd_ack) begin
                shreg <= {flash_pkg::FLASH_READ_CMD,
                          rd_adr[flash_pkg::FLASH_ADDR_BITS-1:2], 2'b00};
            end
        end else if (state == flash_pkg::st_shift_out) begin
            // Next bit goes out as sck falls
            if (cnt[0]) begin
                shreg <= {shreg[30:0], 1'b0};
            end
        end else if (state == flash_pkg::st_shift_in) begin
            // sck is still high here and miso only changes on the fall
            if (cnt[0]) begin
                shreg <= {shreg[30:0], spi_miso};
            end
        end
    end

    // Ack comes only after the chip select has been released
    a_ack_cs_high : assert property (@(posedge ck) disable iff (reset_loop)
        !spi_cs |-> !rd_ack);

    // Mode 0 idle level holds outside a transaction
    a_sck_idle_low : assert property (@(posedge ck) disable iff (reset_loop)
        spi_cs |-> !spi_sck);

endmodule

//--- flash_pkg.sv
/*
 * Shared constants and state types for the flash XIP fetch path.
 * Sizes follow the 03h read command format and are not meant to be changed.
 */

package flash_pkg;

    // Flash byte address carried in the read command
    localparam int FLASH_ADDR_BITS = 24;

    // Standard single-lane read opcode
    localparam logic [7:0] FLASH_READ_CMD = 8'h03;

    // Data-bus address byte [31:24] that selects the flash window
    localparam logic [7:0] DBUS_WIN_TAG = 8'h40;

    // Command, address and one data word, in sck periods
    localparam int XFER_BITS = 8 + FLASH_ADDR_BITS + 32;

    typedef enum logic [1:0] {
        st_idle,
        st_shift_out,
        st_shift_in,
        st_done
    } reader_state_e;

    typedef enum logic [1:0] {
        own_none,
        own_ibus,
        own_dbus
    } arb_owner_e;

endpackage
